/* hw/vlsu_pkg.sv */
package vlsu_pkg;

  ////////////////////
  // Register file
  ////////////////////

  // One lane, so a register-file word is one 32-bit element slot
  localparam int unsigned ElemWidth = 32;
  localparam int unsigned ElemBytes = ElemWidth / 8;

  localparam int unsigned VregWords    = 8;
  localparam int unsigned NrVregs      = 32;
  localparam int unsigned VregIdWidth  = $clog2(NrVregs);
  localparam int unsigned VrfAddrWidth = 8;

  ////////////////////
  // Instruction
  ////////////////////

  // Holds both the element count and the byte count
  localparam int unsigned VlWidth = 6;

  // Instruction tag returned with the response
  localparam int unsigned InsnIdWidth = 5;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    ew_8  = 2'd0,
    ew_16 = 2'd1,
    ew_32 = 2'd2
  } vsew_e;

  typedef enum logic {
    op_vle = 1'b0,
    op_vse = 1'b1
  } vlsu_op_e;

endpackage

/* hw/vlsu_mem_pkg.sv */
package vlsu_mem_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Buffer depth, which also bounds the loads in flight
  localparam int unsigned NrOutstanding = 8;
  localparam int unsigned IdWidth       = $clog2(NrOutstanding);

endpackage

/* hw/vlsu_sequencer.sv */
module vlsu_sequencer (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Instruction request and response
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  vlsu_pkg::vlsu_op_e                   req_op_i,
  input  vlsu_pkg::vsew_e                      req_vsew_i,
  input  logic [vlsu_pkg::VlWidth-1:0]         req_vl_i,
  input  logic [vlsu_mem_pkg::AddrWidth-1:0]   req_base_i,
  input  logic [vlsu_pkg::VregIdWidth-1:0]     req_vd_i,
  input  logic [vlsu_pkg::InsnIdWidth-1:0]     req_id_i,
  output logic                                 rsp_valid_o,
  output logic [vlsu_pkg::InsnIdWidth-1:0]     rsp_id_o,
  output logic [vlsu_pkg::VregIdWidth-1:0]     rsp_vd_o,
  // Register-file port control
  output logic                                 start_o,
  output vlsu_pkg::vlsu_op_e                   op_o,
  output logic [vlsu_pkg::VregIdWidth-1:0]     vd_o,
  output vlsu_pkg::vsew_e                      vsew_o,
  output logic [vlsu_pkg::VlWidth-1:0]         nbytes_o,
  input  logic                                 vrf_done_i,
  // Memory request
  output logic                                 mem_valid_o,
  input  logic                                 mem_ready_i,
  output logic [vlsu_mem_pkg::AddrWidth-1:0]   mem_addr_o,
  output logic                                 mem_we_o,
  output logic [vlsu_mem_pkg::StrbWidth-1:0]   mem_strb_o,
  output logic [vlsu_mem_pkg::DataWidth-1:0]   mem_wdata_o,
  output logic [vlsu_mem_pkg::IdWidth-1:0]     mem_id_o,
  output logic                                 mem_last_o,
  // Reorder buffer
  input  logic                                 buf_full_i,
  input  logic [vlsu_mem_pkg::IdWidth-1:0]     buf_alloc_id_i,
  output logic                                 buf_alloc_o,
  input  logic                                 buf_valid_i,
  input  logic [vlsu_mem_pkg::DataWidth-1:0]   buf_rdata_i,
  input  logic [vlsu_mem_pkg::IdWidth-1:0]     buf_rid_i,
  output logic                                 buf_pop_o
);

  import vlsu_pkg::*;
  import vlsu_mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_resp
  } seq_state_e;

  seq_state_e             state_q;
  logic                   accept;
  logic                   is_load;
  logic                   start_q;
  logic                   vrf_seen_q;
  logic                   mem_xfer;
  logic                   mem_done;
  logic [VlWidth-1:0]     mem_cnt_q;
  logic [VlWidth-1:0]     mem_left;
  logic [AddrWidth-1:0]   base_q;
  logic [InsnIdWidth-1:0] id_q;

  // A finished instruction leaves the unit free again in its response cycle
  assign req_ready_o = state_q != st_run;
  assign accept      = req_valid_i & req_ready_o;
  assign is_load     = op_o == op_vle;

  assign rsp_valid_o = state_q == st_resp;
  assign rsp_id_o    = id_q;
  assign rsp_vd_o    = vd_o;
  assign start_o     = start_q;

  ////////////////////
  // Memory side
  ////////////////////

  assign mem_left   = nbytes_o - mem_cnt_q;
  assign mem_done   = mem_left == '0;
  assign mem_last_o = mem_left <= VlWidth'(ElemBytes);

  // Loads need a free buffer id, stores need the next word in order
  assign mem_valid_o = (state_q == st_run) & ~mem_done & (is_load ? ~buf_full_i : buf_valid_i);
  assign mem_xfer    = mem_valid_o & mem_ready_i;

  assign mem_addr_o  = base_q + AddrWidth'(mem_cnt_q);
  assign mem_we_o    = ~is_load;
  assign mem_wdata_o = buf_rdata_i;
  assign mem_id_o    = is_load ? buf_alloc_id_i : buf_rid_i;

  assign buf_alloc_o = mem_xfer & is_load;
  assign buf_pop_o   = mem_xfer & ~is_load;

  // Full strobe except for the tail of the last word
  always_comb begin
    for (int b = 0; b < StrbWidth; b++) begin
      mem_strb_o[b] = b < mem_left;
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      start_q    <= 1'b0;
      vrf_seen_q <= 1'b0;
      op_o       <= op_vle;
      nbytes_o   <= '0;
      mem_cnt_q  <= '0;
    end else begin
      start_q <= accept;
      if (vrf_done_i) begin
        vrf_seen_q <= 1'b1;
      end
      unique case (state_q)
        st_idle, st_resp: begin
          state_q <= st_idle;
          if (accept) begin
            state_q    <= st_run;
            vrf_seen_q <= 1'b0;
            op_o       <= req_op_i;
            // Elements to bytes by a shift of log2 of the element size
            nbytes_o   <= req_vl_i << req_vsew_i;
            mem_cnt_q  <= '0;
          end
        end
        st_run: begin
          if (mem_xfer) begin
            mem_cnt_q <= mem_last_o ? nbytes_o : mem_cnt_q + VlWidth'(ElemBytes);
          end
          if (mem_done && (vrf_seen_q || vrf_done_i)) begin
            state_q <= st_resp;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Instruction fields kept for the whole run
  always_ff @(posedge clk_i) begin
    if (accept) begin
      vsew_o <= req_vsew_i;
      vd_o   <= req_vd_i;
      id_q   <= req_id_i;
      base_q <= req_base_i;
    end
  end

endmodule

/* hw/vlsu_reorder_buffer.sv */
module vlsu_reorder_buffer (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Id allocation
  input  logic                               alloc_i,
  output logic [vlsu_mem_pkg::IdWidth-1:0]   alloc_id_o,
  output logic                               full_o,
  // Writes by id, in any order
  input  logic                               push_i,
  input  logic [vlsu_mem_pkg::IdWidth-1:0]   push_id_i,
  input  logic [vlsu_mem_pkg::DataWidth-1:0] push_data_i,
  // In-order read side
  input  logic                               pop_i,
  output logic                               valid_o,
  output logic [vlsu_mem_pkg::DataWidth-1:0] rdata_o,
  output logic [vlsu_mem_pkg::IdWidth-1:0]   rid_o
);

  import vlsu_mem_pkg::*;

  logic [DataWidth-1:0]     data_q [NrOutstanding];
  logic [NrOutstanding-1:0] valid_q;
  // Entry handed out and not yet popped
  logic [NrOutstanding-1:0] used_q;
  logic [IdWidth-1:0]       alloc_ptr_q;
  logic [IdWidth-1:0]       rd_ptr_q;

  assign alloc_id_o = alloc_ptr_q;
  assign full_o     = used_q[alloc_ptr_q];

  assign valid_o = valid_q[rd_ptr_q];
  assign rdata_o = data_q[rd_ptr_q];
  assign rid_o   = rd_ptr_q;

  ////////////////////
  // Flags, pointers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q     <= '0;
      used_q      <= '0;
      alloc_ptr_q <= '0;
      rd_ptr_q    <= '0;
    end else begin
      if (alloc_i) begin
        used_q[alloc_ptr_q] <= 1'b1;
        alloc_ptr_q         <= alloc_ptr_q + 1'b1;
      end
      if (push_i) begin
        valid_q[push_id_i] <= 1'b1;
      end
      // The read entry is always allocated, so it never collides with alloc
      if (pop_i) begin
        valid_q[rd_ptr_q] <= 1'b0;
        used_q[rd_ptr_q]  <= 1'b0;
        rd_ptr_q          <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[push_id_i] <= push_data_i;
    end
  end

endmodule

/* hw/vlsu_vrf_port.sv */
module vlsu_vrf_port (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Control from the sequencer
  input  logic                                 start_i,
  input  vlsu_pkg::vlsu_op_e                   op_i,
  input  logic [vlsu_pkg::VregIdWidth-1:0]     vd_i,
  input  logic [vlsu_pkg::VlWidth-1:0]         nbytes_i,
  output logic                                 done_o,
  // Reorder buffer
  input  logic                                 buf_valid_i,
  input  logic [vlsu_pkg::ElemWidth-1:0]       buf_rdata_i,
  output logic                                 buf_pop_o,
  input  logic                                 buf_full_i,
  input  logic [vlsu_mem_pkg::IdWidth-1:0]     buf_alloc_id_i,
  output logic                                 buf_alloc_o,
  output logic                                 buf_push_o,
  output logic [vlsu_mem_pkg::IdWidth-1:0]     buf_push_id_o,
  output logic [vlsu_pkg::ElemWidth-1:0]       buf_push_data_o,
  // Register file write
  output logic                                 vrf_we_o,
  output logic [vlsu_pkg::VrfAddrWidth-1:0]    vrf_waddr_o,
  output logic [vlsu_pkg::ElemWidth-1:0]       vrf_wdata_o,
  output logic [vlsu_pkg::ElemBytes-1:0]       vrf_wbe_o,
  input  logic                                 vrf_wvalid_i,
  // Register file read
  output logic                                 vrf_re_o,
  output logic [vlsu_pkg::VrfAddrWidth-1:0]    vrf_raddr_o,
  input  logic [vlsu_pkg::ElemWidth-1:0]       vrf_rdata_i,
  input  logic                                 vrf_rvalid_i
);

  import vlsu_pkg::*;

  logic                    active_q;
  logic                    done_q;
  vlsu_op_e                op_q;
  logic [VregIdWidth-1:0]  vd_q;
  logic [VlWidth-1:0]      nbytes_q;
  logic [VlWidth-1:0]      cnt_q;
  logic [VlWidth-1:0]      left;
  logic                    last;
  logic                    xfer;
  logic [VrfAddrWidth-1:0] word_addr;

  assign left = nbytes_q - cnt_q;
  assign last = left <= VlWidth'(ElemBytes);

  // Register vd starts at word vd*VregWords
  assign word_addr = VrfAddrWidth'(vd_q * VregWords) + VrfAddrWidth'(cnt_q >> $clog2(ElemBytes));

  always_comb begin
    for (int b = 0; b < ElemBytes; b++) begin
      vrf_wbe_o[b] = b < left;
    end
  end

  ////////////////////
  // Load path
  ////////////////////

  // Buffer head goes straight to the register file, in order
  assign vrf_we_o    = active_q & (op_q == op_vle) & buf_valid_i;
  assign vrf_waddr_o = word_addr;
  assign vrf_wdata_o = buf_rdata_i;
  assign buf_pop_o   = vrf_we_o & vrf_wvalid_i;

  ////////////////////
  // Store path
  ////////////////////

  // Read only when the word has a buffer slot to land in
  assign vrf_re_o        = active_q & (op_q == op_vse) & ~buf_full_i;
  assign vrf_raddr_o     = word_addr;
  assign buf_push_o      = vrf_re_o & vrf_rvalid_i;
  assign buf_alloc_o     = buf_push_o;
  assign buf_push_id_o   = buf_alloc_id_i;
  assign buf_push_data_o = vrf_rdata_i;

  assign xfer   = buf_pop_o | buf_push_o;
  assign done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      op_q     <= op_vle;
      cnt_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        op_q     <= op_i;
        cnt_q    <= '0;
        // An empty access finishes at once
        active_q <= nbytes_i != '0;
        done_q   <= nbytes_i == '0;
      end else if (xfer) begin
        cnt_q <= cnt_q + VlWidth'(ElemBytes);
        if (last) begin
          active_q <= 1'b0;
          done_q   <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      vd_q     <= vd_i;
      nbytes_q <= nbytes_i;
    end
  end

endmodule

/* hw/vlsu_top.sv */
module vlsu_top (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Instruction request
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  input  vlsu_pkg::vlsu_op_e                   req_op_i,
  input  vlsu_pkg::vsew_e                      req_vsew_i,
  input  logic [vlsu_pkg::VlWidth-1:0]         req_vl_i,
  input  logic [vlsu_mem_pkg::AddrWidth-1:0]   req_base_i,
  input  logic [vlsu_pkg::VregIdWidth-1:0]     req_vd_i,
  input  logic [vlsu_pkg::InsnIdWidth-1:0]     req_id_i,
  // Response
  output logic                                 rsp_valid_o,
  output logic [vlsu_pkg::InsnIdWidth-1:0]     rsp_id_o,
  output logic [vlsu_pkg::VregIdWidth-1:0]     rsp_vd_o,
  // Memory request
  output logic                                 mem_valid_o,
  input  logic                                 mem_ready_i,
  output logic [vlsu_mem_pkg::AddrWidth-1:0]   mem_addr_o,
  output logic                                 mem_we_o,
  output logic [vlsu_mem_pkg::StrbWidth-1:0]   mem_strb_o,
  output logic [vlsu_mem_pkg::DataWidth-1:0]   mem_wdata_o,
  output logic [vlsu_mem_pkg::IdWidth-1:0]     mem_id_o,
  output logic                                 mem_last_o,
  // Memory result, loads only
  input  logic                                 result_valid_i,
  input  logic [vlsu_mem_pkg::IdWidth-1:0]     result_id_i,
  input  logic [vlsu_mem_pkg::DataWidth-1:0]   result_rdata_i,
  // Register file
  output logic                                 vrf_we_o,
  output logic [vlsu_pkg::VrfAddrWidth-1:0]    vrf_waddr_o,
  output logic [vlsu_pkg::ElemWidth-1:0]       vrf_wdata_o,
  output logic [vlsu_pkg::ElemBytes-1:0]       vrf_wbe_o,
  input  logic                                 vrf_wvalid_i,
  output logic                                 vrf_re_o,
  output logic [vlsu_pkg::VrfAddrWidth-1:0]    vrf_raddr_o,
  input  logic [vlsu_pkg::ElemWidth-1:0]       vrf_rdata_i,
  input  logic                                 vrf_rvalid_i
);

  import vlsu_pkg::*;
  import vlsu_mem_pkg::*;

  // Sequencer to register-file port
  logic                   start;
  vlsu_op_e               op;
  logic [VregIdWidth-1:0] vd;
  logic [VlWidth-1:0]     nbytes;
  logic                   vrf_done;

  // Reorder buffer
  logic                 seq_alloc;
  logic                 seq_pop;
  logic                 port_alloc;
  logic                 port_pop;
  logic                 port_push;
  logic [IdWidth-1:0]   port_push_id;
  logic [DataWidth-1:0] port_push_data;
  logic                 buf_push;
  logic [IdWidth-1:0]   buf_push_id;
  logic [DataWidth-1:0] buf_push_data;
  logic [IdWidth-1:0]   buf_alloc_id;
  logic                 buf_full;
  logic                 buf_valid;
  logic [DataWidth-1:0] buf_rdata;
  logic [IdWidth-1:0]   buf_rid;

  // Loads fill the buffer from memory, stores from the register file
  assign buf_push      = (op == op_vle) ? result_valid_i : port_push;
  assign buf_push_id   = (op == op_vle) ? result_id_i : port_push_id;
  assign buf_push_data = (op == op_vle) ? result_rdata_i : port_push_data;

  vlsu_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_vsew_i    (req_vsew_i),
    .req_vl_i      (req_vl_i),
    .req_base_i    (req_base_i),
    .req_vd_i      (req_vd_i),
    .req_id_i      (req_id_i),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_id_o      (rsp_id_o),
    .rsp_vd_o      (rsp_vd_o),
    .start_o       (start),
    .op_o          (op),
    .vd_o          (vd),
    .vsew_o        (),
    .nbytes_o      (nbytes),
    .vrf_done_i    (vrf_done),
    .mem_valid_o   (mem_valid_o),
    .mem_ready_i   (mem_ready_i),
    .mem_addr_o    (mem_addr_o),
    .mem_we_o      (mem_we_o),
    .mem_strb_o    (mem_strb_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_id_o      (mem_id_o),
    .mem_last_o    (mem_last_o),
    .buf_full_i    (buf_full),
    .buf_alloc_id_i(buf_alloc_id),
    .buf_alloc_o   (seq_alloc),
    .buf_valid_i   (buf_valid),
    .buf_rdata_i   (buf_rdata),
    .buf_rid_i     (buf_rid),
    .buf_pop_o     (seq_pop)
  );

  // Only one side allocates and pops for a given op
  vlsu_reorder_buffer u_buffer (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .alloc_i    (seq_alloc | port_alloc),
    .alloc_id_o (buf_alloc_id),
    .full_o     (buf_full),
    .push_i     (buf_push),
    .push_id_i  (buf_push_id),
    .push_data_i(buf_push_data),
    .pop_i      (seq_pop | port_pop),
    .valid_o    (buf_valid),
    .rdata_o    (buf_rdata),
    .rid_o      (buf_rid)
  );

  vlsu_vrf_port u_vrf_port (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (start),
    .op_i           (op),
    .vd_i           (vd),
    .nbytes_i       (nbytes),
    .done_o         (vrf_done),
    .buf_valid_i    (buf_valid),
    .buf_rdata_i    (buf_rdata),
    .buf_pop_o      (port_pop),
    .buf_full_i     (buf_full),
    .buf_alloc_id_i (buf_alloc_id),
    .buf_alloc_o    (port_alloc),
    .buf_push_o     (port_push),
    .buf_push_id_o  (port_push_id),
    .buf_push_data_o(port_push_data),
    .vrf_we_o       (vrf_we_o),
    .vrf_waddr_o    (vrf_waddr_o),
    .vrf_wdata_o    (vrf_wdata_o),
    .vrf_wbe_o      (vrf_wbe_o),
    .vrf_wvalid_i   (vrf_wvalid_i),
    .vrf_re_o       (vrf_re_o),
    .vrf_raddr_o    (vrf_raddr_o),
    .vrf_rdata_i    (vrf_rdata_i),
    .vrf_rvalid_i   (vrf_rvalid_i)
  );

endmodule

/* verification/vlsu_tb_models.sv */
module vlsu_tb_models (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [31:0]                          rand_i,
  // Memory side
  input  logic                                 mem_valid_i,
  output logic                                 mem_ready_o,
  input  logic [vlsu_mem_pkg::AddrWidth-1:0]   mem_addr_i,
  input  logic                                 mem_we_i,
  input  logic [vlsu_mem_pkg::StrbWidth-1:0]   mem_strb_i,
  input  logic [vlsu_mem_pkg::DataWidth-1:0]   mem_wdata_i,
  input  logic [vlsu_mem_pkg::IdWidth-1:0]     mem_id_i,
  output logic                                 result_valid_o,
  output logic [vlsu_mem_pkg::IdWidth-1:0]     result_id_o,
  output logic [vlsu_mem_pkg::DataWidth-1:0]   result_rdata_o,
  // Register file side
  input  logic                                 vrf_we_i,
  input  logic [vlsu_pkg::VrfAddrWidth-1:0]    vrf_waddr_i,
  input  logic [vlsu_pkg::ElemWidth-1:0]       vrf_wdata_i,
  input  logic [vlsu_pkg::ElemBytes-1:0]       vrf_wbe_i,
  output logic                                 vrf_wvalid_o,
  input  logic                                 vrf_re_i,
  input  logic [vlsu_pkg::VrfAddrWidth-1:0]    vrf_raddr_i,
  output logic [vlsu_pkg::ElemWidth-1:0]       vrf_rdata_o,
  output logic                                 vrf_rvalid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import vlsu_pkg::*;
  import vlsu_mem_pkg::*;

  logic [7:0]         mem_bytes [256];
  logic [7:0]         vrf_bytes [NrVregs*VregWords*ElemBytes];
  logic [IdWidth-1:0] pend_id [$];
  logic [31:0]        pend_data [$];

  // Reads answer in the same cycle
  assign vrf_rvalid_o = vrf_re_i;
  always_comb begin
    for (int b = 0; b < ElemBytes; b++) begin
      vrf_rdata_o[8*b +: 8] = vrf_bytes[vrf_raddr_i*ElemBytes + b];
    end
  end

  initial begin
    mem_ready_o    = 1'b0;
    result_valid_o = 1'b0;
    result_id_o    = '0;
    result_rdata_o = '0;
    vrf_wvalid_o   = 1'b0;
  end

  always @(posedge clk_i) begin
    int unsigned pick;
    logic [31:0] word;
    if (rst_i) begin
      mem_ready_o    <= 1'b0;
      result_valid_o <= 1'b0;
      vrf_wvalid_o   <= 1'b0;
      pend_id.delete();
      pend_data.delete();
    end else begin
      mem_ready_o  <= rand_i[0];
      vrf_wvalid_o <= rand_i[1];
      if (mem_valid_i && mem_ready_o) begin
        if (mem_we_i) begin
          for (int b = 0; b < StrbWidth; b++) begin
            if (mem_strb_i[b]) begin
              mem_bytes[8'(mem_addr_i + b)] = mem_wdata_i[8*b +: 8];
            end
          end
        end else begin
          for (int b = 0; b < 4; b++) begin
            word[8*b +: 8] = mem_bytes[8'(mem_addr_i + b)];
          end
          pend_id.push_back(mem_id_i);
          pend_data.push_back(word);
        end
      end
      // Pick any pending load, so results come back out of order
      result_valid_o <= 1'b0;
      if (pend_id.size() > 0 && rand_i[2]) begin
        pick = rand_i[15:8] % pend_id.size();
        result_valid_o <= 1'b1;
        result_id_o    <= pend_id[pick];
        result_rdata_o <= pend_data[pick];
        pend_id.delete(pick);
        pend_data.delete(pick);
      end
      if (vrf_we_i && vrf_wvalid_o) begin
        for (int b = 0; b < ElemBytes; b++) begin
          if (vrf_wbe_i[b]) begin
            vrf_bytes[vrf_waddr_i*ElemBytes + b] = vrf_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

/* verification/vlsu_tb.sv */
module vlsu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import vlsu_pkg::*;
  import vlsu_mem_pkg::*;

  // 17 instructions in the sequence below
  localparam int unsigned NrInsns    = 17;
  localparam int unsigned CycleLimit = 400 * (NrInsns + 1);

  logic clk_i = 1'b0;
  logic rst_i;
  logic                    req_valid_i;
  logic                    req_ready_o;
  vlsu_op_e                req_op_i;
  vsew_e                   req_vsew_i;
  logic [VlWidth-1:0]      req_vl_i;
  logic [AddrWidth-1:0]    req_base_i;
  logic [VregIdWidth-1:0]  req_vd_i;
  logic [InsnIdWidth-1:0]  req_id_i;
  logic                    rsp_valid_o;
  logic [InsnIdWidth-1:0]  rsp_id_o;
  logic [VregIdWidth-1:0]  rsp_vd_o;
  logic                    mem_valid_o;
  logic                    mem_ready_i;
  logic                    mem_we_o;
  logic                    mem_last_o;
  logic [AddrWidth-1:0]    mem_addr_o;
  logic [StrbWidth-1:0]    mem_strb_o;
  logic [DataWidth-1:0]    mem_wdata_o;
  logic [IdWidth-1:0]      mem_id_o;
  logic                    result_valid_i;
  logic [IdWidth-1:0]      result_id_i;
  logic [DataWidth-1:0]    result_rdata_i;
  logic                    vrf_we_o;
  logic                    vrf_wvalid_i;
  logic                    vrf_re_o;
  logic                    vrf_rvalid_i;
  logic [VrfAddrWidth-1:0] vrf_waddr_o;
  logic [VrfAddrWidth-1:0] vrf_raddr_o;
  logic [ElemWidth-1:0]    vrf_wdata_o;
  logic [ElemWidth-1:0]    vrf_rdata_i;
  logic [ElemBytes-1:0]    vrf_wbe_o;

  logic [31:0] stim_rnd = 32'he6f6;
  logic [31:0] model_rnd;
  logic [7:0]  exp_mem [256];
  logic [7:0]  exp_vrf [1024];
  // Current instruction as seen by the monitor
  vlsu_op_e               cur_op;
  logic [AddrWidth-1:0]   cur_base;
  logic [VregIdWidth-1:0] cur_vd;
  logic [InsnIdWidth-1:0] cur_id;
  int unsigned cur_nbytes;
  int unsigned issued;
  int unsigned mem_xfers;
  int unsigned vrf_acts;
  int unsigned rsp_count;
  int unsigned cycles;

  always #20 clk_i = ~clk_i;

  vlsu_top DUT (.*);

  vlsu_tb_models u_models (
    .clk_i(clk_i), .rst_i(rst_i), .rand_i(model_rnd),
    .mem_valid_i(mem_valid_o), .mem_ready_o(mem_ready_i), .mem_addr_i(mem_addr_o),
    .mem_we_i(mem_we_o), .mem_strb_i(mem_strb_o), .mem_wdata_i(mem_wdata_o),
    .mem_id_i(mem_id_o), .result_valid_o(result_valid_i), .result_id_o(result_id_i),
    .result_rdata_o(result_rdata_i), .vrf_we_i(vrf_we_o), .vrf_waddr_i(vrf_waddr_o),
    .vrf_wdata_i(vrf_wdata_o), .vrf_wbe_i(vrf_wbe_o), .vrf_wvalid_o(vrf_wvalid_i),
    .vrf_re_i(vrf_re_o), .vrf_raddr_i(vrf_raddr_o), .vrf_rdata_o(vrf_rdata_i),
    .vrf_rvalid_o(vrf_rvalid_i)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rnd = xorshift(stim_rnd);
    return stim_rnd;
  endfunction

  // Element size in bytes for each element width
  function automatic int unsigned sew_bytes(vsew_e sew);
    case (sew)
      ew_8:    return 1;
      ew_16:   return 2;
      ew_32:   return 4;
      default: return 0;
    endcase
  endfunction

  // Byte j of the access is memory base+j and register byte vd*32+j
  function automatic void predict_access(vlsu_op_e op, int unsigned base, int unsigned vd,
                                         int unsigned nbytes);
    for (int unsigned j = 0; j < nbytes; j++) begin
      if (op == op_vle) begin
        exp_vrf[vd*32 + j] = exp_mem[(base + j) % 256];
      end else begin
        exp_mem[(base + j) % 256] = exp_vrf[vd*32 + j];
      end
    end
  endfunction

  function automatic logic [3:0] strobe_for(int unsigned left);
    return (left >= 4) ? 4'hf : 4'(4'hf >> (4 - left));
  endfunction

  task automatic fail_check(string msg);
    $display("Error: %0d ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk_i) begin
    model_rnd <= xorshift(model_rnd);
    if (!rst_i) begin
      cycles++;
      if (cycles > CycleLimit) begin
        $display("The run hung: no response within %0d cycles", CycleLimit);
        $display("Test failed");
        $fatal(1);
      end
      if (req_valid_i && req_ready_o) begin
        issued = 0;
      end else if (mem_valid_o && mem_ready_i) begin
        assert (mem_addr_o == cur_base + issued && mem_we_o == (cur_op == op_vse) &&
                mem_last_o == (cur_nbytes - issued <= 4) &&
                mem_strb_o == strobe_for(cur_nbytes - issued))
        else fail_check($sformatf("bad memory request at address %0h", mem_addr_o));
        issued += 4;
        mem_xfers++;
      end
      if ((vrf_we_o && vrf_wvalid_i) || vrf_re_o) begin
        vrf_acts++;
      end
      if (rsp_valid_o) begin
        assert (rsp_id_o == cur_id && rsp_vd_o == cur_vd)
        else fail_check($sformatf("response id %0d vd %0d, expected %0d %0d",
                                  rsp_id_o, rsp_vd_o, cur_id, cur_vd));
        rsp_count++;
      end
    end
  end

  task automatic compare_state();
    for (int i = 0; i < 256; i++) begin
      assert (u_models.mem_bytes[i] === exp_mem[i])
      else fail_check($sformatf("memory byte at address %0h is %0h, expected %0h",
                                i, u_models.mem_bytes[i], exp_mem[i]));
    end
    for (int i = 0; i < 1024; i++) begin
      assert (u_models.vrf_bytes[i] === exp_vrf[i])
      else fail_check($sformatf("register byte at address %0h is %0h, expected %0h",
                                i, u_models.vrf_bytes[i], exp_vrf[i]));
    end
  endtask

  task automatic run_insn(vlsu_op_e op, vsew_e sew, int unsigned vl, int unsigned base,
                          int unsigned vd);
    int unsigned xfers_before;
    int unsigned acts_before;
    xfers_before = mem_xfers;
    acts_before  = vrf_acts;
    exp_mem      = u_models.mem_bytes;
    exp_vrf      = u_models.vrf_bytes;
    cur_op       = op;
    cur_base     = base;
    cur_vd       = vd;
    cur_id       = cur_id + 1;
    cur_nbytes   = vl * sew_bytes(sew);
    predict_access(op, base, vd, cur_nbytes);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_vsew_i  <= sew;
    req_vl_i    <= vl;
    req_base_i  <= base;
    req_vd_i    <= vd;
    req_id_i    <= cur_id;
    do @(posedge clk_i); while (!(req_valid_i && req_ready_o));
    req_valid_i <= 1'b0;
    do @(posedge clk_i); while (!rsp_valid_o);
    @(posedge clk_i);
    assert (!rsp_valid_o) else fail_check("response lasted more than one cycle");
    if (vl == 0) begin
      assert (mem_xfers == xfers_before && vrf_acts == acts_before)
      else fail_check("traffic seen for an empty instruction");
    end
    compare_state();
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [7:0]  orig_mem [256];
    int unsigned vl;
    int unsigned base;
    int unsigned vd;
    int unsigned nbytes;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = op_vle;
    req_vsew_i  = ew_8;
    req_vl_i    = '0;
    req_base_i  = '0;
    req_vd_i    = '0;
    req_id_i    = '0;
    cur_id      = '0;
    model_rnd   = xorshift(32'he6f6);
    for (int i = 0; i < 256; i++) begin
      u_models.mem_bytes[i] = 8'(next_stim() ^ i);
    end
    for (int i = 0; i < 1024; i++) begin
      u_models.vrf_bytes[i] = 8'(next_stim() ^ (i >> 2));
    end
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    assert (req_ready_o && !rsp_valid_o && !mem_valid_o && !vrf_we_o && !vrf_re_o)
    else fail_check("outputs not idle after reset");

    for (int rep = 0; rep < 2; rep++) begin
      for (int s = 0; s < 3; s++) begin
        for (int o = 0; o < 2; o++) begin
          vl   = 1 + next_stim() % (32 >> s);
          base = (next_stim() % 56) * 4;
          vd   = next_stim() % NrVregs;
          run_insn(vlsu_op_e'(o), vsew_e'(s), vl, base, vd);
        end
      end
    end
    run_insn(op_vle, ew_32, 0, 16, 3);

    // Load then store back the same register leaves memory unchanged
    for (int s = 0; s < 3; s += 2) begin
      orig_mem = u_models.mem_bytes;
      vl   = 1 + next_stim() % (32 >> s);
      base = (next_stim() % 56) * 4;
      vd   = next_stim() % NrVregs;
      run_insn(op_vle, vsew_e'(s), vl, base, vd);
      // Scribble over the loaded bytes so only the store can restore them
      nbytes = vl * sew_bytes(vsew_e'(s));
      for (int j = 0; j < nbytes; j++) begin
        u_models.mem_bytes[(base + j) % 256] = ~orig_mem[(base + j) % 256];
      end
      run_insn(op_vse, vsew_e'(s), vl, base, vd);
      for (int i = 0; i < 256; i++) begin
        assert (u_models.mem_bytes[i] === orig_mem[i])
        else fail_check($sformatf("round trip changed memory byte at address %0h", i));
      end
    end

    assert (rsp_count == NrInsns) begin
      $display("Test completed successfully");
    end else begin
      fail_check($sformatf("%0d responses, expected %0d", rsp_count, NrInsns));
    end
    $finish;
  end

endmodule

/* list.f */
hw/vlsu_pkg.sv
hw/vlsu_mem_pkg.sv
hw/vlsu_sequencer.sv
hw/vlsu_reorder_buffer.sv
hw/vlsu_vrf_port.sv
hw/vlsu_top.sv
verification/vlsu_tb_models.sv
verification/vlsu_tb.sv

/* Bender.yml */
package:
  name: vlsu

dependencies: {}

sources:
  # Packages first, the RTL uses them by scoped name in port lists
  - hw/vlsu_pkg.sv
  - hw/vlsu_mem_pkg.sv
  - hw/vlsu_sequencer.sv
  - hw/vlsu_reorder_buffer.sv
  - hw/vlsu_vrf_port.sv
  - hw/vlsu_top.sv
  - target: test
    files:
      - verification/vlsu_tb_models.sv
      - verification/vlsu_tb.sv
